//--- flist.f
+incdir+verilog
verilog/line_buffer_pkg.sv
verilog/ring_sync_if.sv
verilog/line_write_ctrl.sv
verilog/line_read_ctrl.sv
verilog/line_store.sv
verilog/edge_pad_mux.sv
verilog/bicubic_line_buffer.sv
verif/tb_bicubic_line_buffer.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the bicubic line buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_bicubic_line_buffer \
    -f flist.f \
    -o sim_tb

# A $fatal in the testbench gives a failing exit status
./obj_dir/sim_tb

//--- verif/tb_bicubic_line_buffer.sv
// **************************************************
// Bicubic line buffer testbench
// **************************************************
`timescale 1ns/1ps
`include "line_buffer_consts.svh"

module tb_bicubic_line_buffer
    import line_buffer_pkg::*;
();

    localparam int CLK_PERIOD     = 100;
    localparam int IMG_W          = `LB_IMAGE_WIDTH;
    localparam int IMG_H          = `LB_IMAGE_HEIGHT;
    localparam int REPEAT         = `LB_REPEAT;
    localparam int FRAMES         = 2;
    localparam int GROUP_BEATS    = REPEAT * IMG_W;
    localparam int FRAME_BEATS    = (IMG_H + 1) * GROUP_BEATS;
    localparam int TOTAL_BEATS    = FRAMES * FRAME_BEATS;
    // Four cycles per beat worst case, plus slack for reset and input gaps
    localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 4 + 2000;

    logic   clk;
    logic   aresetn;
    pixel_t pixel_in;
    logic   pixel_in_valid;
    logic   pixel_in_start_of_frame;
    logic   pixel_in_end_of_line;
    logic   buffer_ready;
    logic   pipeline_ready;
    logic   pixel_out_valid;
    logic   pixel_out_start_of_frame;
    pixel_t pixel_line0;
    pixel_t pixel_line1;
    pixel_t pixel_line2;
    pixel_t pixel_line3;

    integer      seed;
    pixel_t      frame_pix [FRAMES][IMG_H][IMG_W];
    int unsigned frame_beats [FRAMES];
    int unsigned out_beats;
    int unsigned in_beats;
    int unsigned sof_seen;
    int unsigned pad_seen;
    int unsigned pad_target;
    logic        pad_watch;

    bicubic_line_buffer dut_i (
        .clk                      (clk),
        .aresetn                  (aresetn),
        .pixel_in                 (pixel_in),
        .pixel_in_valid           (pixel_in_valid),
        .pixel_in_start_of_frame  (pixel_in_start_of_frame),
        .pixel_in_end_of_line     (pixel_in_end_of_line),
        .buffer_ready             (buffer_ready),
        .pipeline_ready           (pipeline_ready),
        .pixel_out_valid          (pixel_out_valid),
        .pixel_out_start_of_frame (pixel_out_start_of_frame),
        .pixel_line0              (pixel_line0),
        .pixel_line1              (pixel_line1),
        .pixel_line2              (pixel_line2),
        .pixel_line3              (pixel_line3)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Print the reason, then the fail banner, then stop
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_taps(input tap_vec_t got, input tap_vec_t exp);
        for (int k = 0; k < 4; k++) begin
            if (got[k] !== exp[k]) begin
                stop_run($sformatf("FAILED pixel_line%0d: got 0x%h expected 0x%h (beat %0d)",
                                   k, got[k], exp[k], out_beats));
            end
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int unsigned got,
                               input int unsigned exp);
        if (got != exp) begin
            stop_run($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Clamp rule, tap k of group g is row g-2+k held inside the frame
    function automatic tap_vec_t expected_taps(input int frame, input int grp, input int col);
        tap_vec_t t;
        int       row;
        for (int k = 0; k < 4; k++) begin
            row = grp - 2 + k;
            if (row < 0) begin
                row = 0;
            end
            if (row > IMG_H - 1) begin
                row = IMG_H - 1;
            end
            t[k] = frame_pix[frame][row][col];
        end
        return t;
    endfunction

    // One pixel, random idle cycles before it, held until accepted
    task automatic drive_pixel(input pixel_t value, input logic sof, input logic eol);
        int unsigned gap;
        gap = {$random(seed)} % 3;
        repeat (gap) begin
            @(posedge clk);
            pixel_in_valid <= 1'b0;
        end
        @(posedge clk);
        pixel_in                <= value;
        pixel_in_valid          <= 1'b1;
        pixel_in_start_of_frame <= sof;
        pixel_in_end_of_line    <= eol;
        @(negedge clk);
        while (!buffer_ready) begin
            @(negedge clk);
        end
    endtask

    // Input off until the read side runs dry and stalls
    task automatic wait_read_idle();
        @(posedge clk);
        pixel_in_valid <= 1'b0;
        @(negedge clk);
        while (pixel_out_valid) begin
            @(negedge clk);
        end
    endtask

    // Random stalls on the output side, about one cycle in four
    initial begin
        @(posedge aresetn);
        forever begin
            @(posedge clk);
            pipeline_ready <= (({$random(seed)} % 4) != 0);
        end
    end

    // Inputs and outputs sampled mid-cycle, acceptance happens at the next edge
    always @(negedge clk) begin
        if (aresetn === 1'b1) begin
            // Padding phase refuses input until its row group ends
            if (pad_watch) begin
                if (out_beats < pad_target) begin
                    if (buffer_ready) begin
                        stop_run("Input was accepted during the padding phase");
                    end
                end else begin
                    pad_watch = 1'b0;
                    pad_seen++;
                end
            end
            if (pixel_out_valid && pipeline_ready) begin
                if (out_beats >= TOTAL_BEATS) begin
                    stop_run("Output beat accepted after the last expected beat");
                end
                check_taps({pixel_line3, pixel_line2, pixel_line1, pixel_line0},
                           expected_taps(out_beats / FRAME_BEATS,
                                         (out_beats % FRAME_BEATS) / GROUP_BEATS,
                                         out_beats % IMG_W));
                check_flag("pixel_out_start_of_frame", pixel_out_start_of_frame,
                           (out_beats % FRAME_BEATS) == 0);
                if (pixel_out_start_of_frame) begin
                    sof_seen++;
                end
                if (sof_seen > 0 && sof_seen <= FRAMES) begin
                    frame_beats[sof_seen-1]++;
                end
                out_beats++;
            end
            if (pixel_in_valid && buffer_ready) begin
                // Last pixel of the last row opens the padding watch
                if ((in_beats % IMG_W) == IMG_W - 1 &&
                    ((in_beats / IMG_W) % IMG_H) == IMG_H - 1) begin
                    pad_watch  = 1'b1;
                    pad_target = (out_beats / GROUP_BEATS + 1) * GROUP_BEATS;
                end
                in_beats++;
            end
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        stop_run("Timeout, the output did not deliver every beat in time");
    end

    initial begin
        seed                    = 32'h5c44_e7f1;
        aresetn                 <= 1'b0;
        pixel_in                <= '0;
        pixel_in_valid          <= 1'b0;
        pixel_in_start_of_frame <= 1'b0;
        pixel_in_end_of_line    <= 1'b0;
        pipeline_ready          <= 1'b0;
        out_beats               = 0;
        in_beats                = 0;
        sof_seen                = 0;
        pad_seen                = 0;
        pad_target              = 0;
        pad_watch               = 1'b0;
        for (int f = 0; f < FRAMES; f++) begin
            frame_beats[f] = 0;
            for (int r = 0; r < IMG_H; r++) begin
                for (int c = 0; c < IMG_W; c++) begin
                    frame_pix[f][r][c] = pixel_t'($random(seed));
                end
            end
        end

        repeat (4) @(posedge clk);
        aresetn <= 1'b1;

        // Levels right after reset
        @(negedge clk);
        check_flag("buffer_ready", buffer_ready, 1'b1);
        check_flag("pixel_out_valid", pixel_out_valid, 1'b0);

        // Frames back to back, the next one waits out the padding phase
        for (int f = 0; f < FRAMES; f++) begin
            for (int r = 0; r < IMG_H; r++) begin
                for (int c = 0; c < IMG_W; c++) begin
                    // Last pixel lands with room in the ring, so only padding holds input
                    if (r == IMG_H - 1 && c == IMG_W - 1) begin
                        wait_read_idle();
                    end
                    drive_pixel(frame_pix[f][r][c], (r == 0) && (c == 0), c == IMG_W - 1);
                end
            end
        end
        @(posedge clk);
        pixel_in_valid          <= 1'b0;
        pixel_in_start_of_frame <= 1'b0;
        pixel_in_end_of_line    <= 1'b0;

        while (out_beats < TOTAL_BEATS) begin
            @(negedge clk);
        end

        // Ring drained, output stays quiet
        repeat (3 * IMG_W) begin
            @(negedge clk);
            check_flag("pixel_out_valid", pixel_out_valid, 1'b0);
        end

        check_count("total output beats", out_beats, TOTAL_BEATS);
        check_count("start of frame count", sof_seen, FRAMES);
        check_count("padding phases", pad_seen, FRAMES);
        for (int f = 0; f < FRAMES; f++) begin
            check_count($sformatf("frame %0d beats", f), frame_beats[f], FRAME_BEATS);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- verilog/bicubic_line_buffer.sv
// **************************************************
// Bicubic line buffer top
// **************************************************
`timescale 1ns/1ps
`include "line_buffer_consts.svh"

module bicubic_line_buffer
    import line_buffer_pkg::*;
(
    input  logic                       clk,
    input  logic                       aresetn,
    input  logic [`LB_PIXEL_WIDTH-1:0] pixel_in,
    input  logic                       pixel_in_valid,
    input  logic                       pixel_in_start_of_frame,
    input  logic                       pixel_in_end_of_line,
    output logic                       buffer_ready,
    input  logic                       pipeline_ready,
    output logic                       pixel_out_valid,
    output logic                       pixel_out_start_of_frame,
    output logic [`LB_PIXEL_WIDTH-1:0] pixel_line0,
    output logic [`LB_PIXEL_WIDTH-1:0] pixel_line1,
    output logic [`LB_PIXEL_WIDTH-1:0] pixel_line2,
    output logic [`LB_PIXEL_WIDTH-1:0] pixel_line3
);

    ring_sync_if sync ();

    col_t      wr_col;
    line_sel_t wr_sel;
    col_t      rd_col;
    pad_e      pad;
    tap_vec_t  taps_raw;
    tap_vec_t  taps_pad;

    line_write_ctrl u_write (
        .clk                  (clk),
        .aresetn              (aresetn),
        .pixel_in_valid       (pixel_in_valid),
        .pixel_in_end_of_line (pixel_in_end_of_line),
        .sync                 (sync.write),
        .wr_col               (wr_col),
        .wr_sel               (wr_sel)
    );

    line_read_ctrl u_read (
        .clk                      (clk),
        .aresetn                  (aresetn),
        .pipeline_ready           (pipeline_ready),
        .pixel_in_valid           (pixel_in_valid),
        .pixel_in_end_of_line     (pixel_in_end_of_line),
        .sync                     (sync.read),
        .rd_col                   (rd_col),
        .pad                      (pad),
        .pixel_out_valid          (pixel_out_valid),
        .pixel_out_start_of_frame (pixel_out_start_of_frame)
    );

    line_store u_store (
        .clk        (clk),
        .wr_col     (wr_col),
        .wr_sel     (wr_sel),
        .wr_data    (pixel_in),
        .rd_col     (rd_col),
        .active_sel (sync.active_sel),
        .taps       (taps_raw)
    );

    edge_pad_mux u_pad (
        .pad      (pad),
        .taps_in  (taps_raw),
        .taps_out (taps_pad)
    );

    assign buffer_ready = sync.in_ready;

    assign pixel_line0 = taps_pad[0];
    assign pixel_line1 = taps_pad[1];
    assign pixel_line2 = taps_pad[2];
    assign pixel_line3 = taps_pad[3];

    // Frame start only at the first column of a row
    a_sof_col0: assert property (@(posedge clk) disable iff (!aresetn)
        (pixel_in_valid && buffer_ready && pixel_in_start_of_frame) |-> (wr_col == '0));

endmodule

//--- verilog/edge_pad_mux.sv
// **************************************************
// Top and bottom edge padding
// **************************************************
`timescale 1ns/1ps

module edge_pad_mux
    import line_buffer_pkg::*;
(
    input  pad_e     pad,
    input  tap_vec_t taps_in,
    output tap_vec_t taps_out
);

    // Clamp of rows r-2 .. r+1 into the frame
    always_comb begin
        taps_out = taps_in;
        case (pad)
            // Rows -2 and -1 take row 0
            PAD_TOP0: begin
                taps_out[0] = taps_in[2];
                taps_out[1] = taps_in[2];
            end
            // Row -1 takes row 0
            PAD_TOP1: begin
                taps_out[0] = taps_in[1];
            end
            // Row H takes row H-1
            PAD_BOT1: begin
                taps_out[3] = taps_in[2];
            end
            // Rows H and H+1 take row H-1
            PAD_BOT0: begin
                taps_out[2] = taps_in[1];
                taps_out[3] = taps_in[1];
            end
            default: begin
                taps_out = taps_in;
            end
        endcase
    end

endmodule

//--- verilog/line_store.sv
// **************************************************
// Line memories and tap rotation
// **************************************************
`timescale 1ns/1ps
`include "line_buffer_consts.svh"

module line_store
    import line_buffer_pkg::*;
(
    input  logic      clk,
    input  col_t      wr_col,
    input  line_sel_t wr_sel,
    input  pixel_t    wr_data,
    input  col_t      rd_col,
    input  line_sel_t active_sel,
    output tap_vec_t  taps
);

    pixel_t    rd_word [`LB_NUM_LINES];
    line_sel_t sel_pipe [`LB_RAM_LATENCY];
    line_sel_t sel_q;

    // One simple dual-port memory per line
    for (genvar i = 0; i < `LB_NUM_LINES; i++) begin : g_line
        pixel_t ram [`LB_IMAGE_WIDTH];
        pixel_t rd_q;

        always_ff @(posedge clk) begin
            if (wr_sel[i]) begin
                ram[wr_col] <= wr_data;
            end
            // Registered read, one cycle latency
            rd_q <= ram[rd_col];
        end

        assign rd_word[i] = rd_q;
    end

    // Select follows the read data through the memory latency
    always_ff @(posedge clk) begin
        sel_pipe[0] <= active_sel;
        for (int s = 1; s < `LB_RAM_LATENCY; s++) begin
            sel_pipe[s] <= sel_pipe[s-1];
        end
    end

    assign sel_q = sel_pipe[`LB_RAM_LATENCY-1];

    // Oldest line first, taps walk up the ring
    always_comb begin
        taps = '0;
        for (int i = 0; i < `LB_NUM_LINES; i++) begin
            if (sel_q[i]) begin
                for (int k = 0; k < 4; k++) begin
                    taps[k] = rd_word[(i + k) % `LB_NUM_LINES];
                end
            end
        end
    end

endmodule

//--- verilog/line_read_ctrl.sv
// **************************************************
// Line buffer read controller
// **************************************************
`timescale 1ns/1ps
`include "line_buffer_consts.svh"

module line_read_ctrl
    import line_buffer_pkg::*;
(
    input  logic      clk,
    input  logic      aresetn,
    input  logic      pipeline_ready,
    input  logic      pixel_in_valid,
    input  logic      pixel_in_end_of_line,
    ring_sync_if.read sync,
    output col_t      rd_col,
    output pad_e      pad,
    output logic      pixel_out_valid,
    output logic      pixel_out_start_of_frame
);

    rd_state_e state_q;
    rd_state_e state_nxt;
    col_t      col_q;
    col_t      col_nxt;
    rep_t      rep_q;
    rep_t      rep_nxt;
    row_t      grp_q;
    row_t      grp_nxt;
    pad_e      pad_q;
    logic      beat_acc;
    logic      last_col;
    logic      last_rep;
    logic      last_grp;
    logic      eol_acc;
    int        fill_nxt;

    // Real rows still needed in the window for group g
    function automatic int lines_needed(input row_t g);
        if (g <= row_t'(`LB_IMAGE_HEIGHT - 2)) begin
            return 2;
        end else if (g == row_t'(`LB_IMAGE_HEIGHT - 1)) begin
            return 1;
        end
        return 0;
    endfunction

    // Edge code from the row group
    function automatic pad_e pad_code(input row_t g);
        if (g == row_t'(0)) begin
            return PAD_TOP0;
        end else if (g == row_t'(1)) begin
            return PAD_TOP1;
        end else if (g == row_t'(`LB_IMAGE_HEIGHT - 1)) begin
            return PAD_BOT1;
        end else if (g == row_t'(`LB_IMAGE_HEIGHT)) begin
            return PAD_BOT0;
        end
        return PAD_NONE;
    endfunction

    assign pixel_out_valid = (state_q == RD_STREAM);
    assign beat_acc        = pixel_out_valid & pipeline_ready;

    assign last_col = (col_q == col_t'(`LB_IMAGE_WIDTH - 1));
    assign last_rep = (rep_q == rep_t'(`LB_REPEAT - 1));
    assign last_grp = (grp_q == row_t'(`LB_IMAGE_HEIGHT));

    assign sync.line_done = beat_acc & last_col & last_rep;

    // Mirror of the write side fill update
    assign eol_acc  = pixel_in_valid & pixel_in_end_of_line & sync.in_ready;
    assign fill_nxt = int'(sync.fill) + int'(eol_acc) - int'(sync.line_done && !last_grp);

    // Next beat position, also the memory read address
    always_comb begin
        col_nxt = col_q;
        rep_nxt = rep_q;
        grp_nxt = grp_q;
        if (beat_acc) begin
            col_nxt = last_col ? '0 : col_q + 1'b1;
            if (last_col) begin
                rep_nxt = last_rep ? '0 : rep_q + 1'b1;
                if (last_rep) begin
                    grp_nxt = last_grp ? '0 : grp_q + 1'b1;
                end
            end
        end
    end

    assign rd_col = col_nxt;

    // Stream while the window holds every real row of the group
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            RD_IDLE: begin
                if (fill_nxt >= lines_needed(grp_q)) begin
                    state_nxt = RD_STREAM;
                end
            end
            RD_STREAM: begin
                // Ring drained, wait for input
                if (sync.line_done && fill_nxt < lines_needed(grp_nxt)) begin
                    state_nxt = RD_IDLE;
                end
            end
            default: state_nxt = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge aresetn) begin
        if (!aresetn) begin
            state_q <= RD_IDLE;
            col_q   <= '0;
            rep_q   <= '0;
            grp_q   <= '0;
            pad_q   <= PAD_TOP0;
        end else begin
            state_q <= state_nxt;
            col_q   <= col_nxt;
            rep_q   <= rep_nxt;
            grp_q   <= grp_nxt;
            // One cycle ahead so it matches the memory data
            pad_q   <= pad_code(grp_nxt);
        end
    end

    assign pad = pad_q;

    assign pixel_out_start_of_frame = pixel_out_valid & (grp_q == '0) &
                                      (rep_q == '0) & (col_q == '0);

    a_grp_range: assert property (@(posedge clk) disable iff (!aresetn)
        grp_q <= row_t'(`LB_IMAGE_HEIGHT));

    // Padding only ends at a line_done, so the read side has to be streaming
    a_pad_streams: assert property (@(posedge clk) disable iff (!aresetn)
        sync.padding |-> pixel_out_valid);

endmodule

//--- verilog/line_write_ctrl.sv
// **************************************************
// Line buffer write controller
// **************************************************
`timescale 1ns/1ps
`include "line_buffer_consts.svh"

module line_write_ctrl
    import line_buffer_pkg::*;
(
    input  logic       clk,
    input  logic       aresetn,
    input  logic       pixel_in_valid,
    input  logic       pixel_in_end_of_line,
    ring_sync_if.write sync,
    output col_t       wr_col,
    output line_sel_t  wr_sel
);

    col_t      col_q;
    row_t      in_row_q;
    row_t      done_grp_q;
    fill_t     fill_q;
    logic      padding_q;
    line_sel_t active_q;
    line_sel_t active_nxt;
    logic      accept;
    logic      eol_acc;
    logic      last_row;
    logic      wrap;
    logic      rotate;

    // Rotate a one-hot selection up by n memories
    function automatic line_sel_t rot_sel(input line_sel_t sel, input int unsigned n);
        line_sel_t r;
        r = sel;
        for (int unsigned i = 0; i < `LB_NUM_LINES; i++) begin
            if (i < n) begin
                r = {r[`LB_NUM_LINES-2:0], r[`LB_NUM_LINES-1]};
            end
        end
        return r;
    endfunction

    assign accept   = pixel_in_valid & sync.in_ready;
    assign eol_acc  = accept & pixel_in_end_of_line;
    assign last_row = (in_row_q == row_t'(`LB_IMAGE_HEIGHT - 1));

    // No rotation between the last group of a frame and group 0 of the next
    assign wrap   = (done_grp_q == row_t'(`LB_IMAGE_HEIGHT));
    assign rotate = sync.line_done & ~wrap;

    assign active_nxt = rotate ? rot_sel(active_q, 1) : active_q;

    // Full at three lines, or while padding
    assign sync.in_ready   = ~padding_q & (fill_q <= fill_t'(2));
    assign sync.fill       = fill_q;
    assign sync.padding    = padding_q;
    assign sync.active_sel = active_nxt;

    // Write slot sits fill+2 memories past the oldest tap
    assign wr_col = col_q;
    assign wr_sel = accept ? rot_sel(active_q, int'(fill_q) + 2) : '0;

    always_ff @(posedge clk, negedge aresetn) begin
        if (!aresetn) begin
            col_q    <= '0;
            in_row_q <= '0;
        end else if (accept) begin
            if (pixel_in_end_of_line) begin
                col_q <= '0;
                // Input rows wrap per frame
                in_row_q <= last_row ? '0 : in_row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    // Row groups completed by the read side
    always_ff @(posedge clk, negedge aresetn) begin
        if (!aresetn) begin
            done_grp_q <= '0;
        end else if (sync.line_done) begin
            done_grp_q <= wrap ? '0 : done_grp_q + 1'b1;
        end
    end

    always_ff @(posedge clk, negedge aresetn) begin
        if (!aresetn) begin
            fill_q    <= '0;
            padding_q <= 1'b0;
            // Memory 0 holds the oldest tap
            active_q  <= line_sel_t'(1);
        end else begin
            active_q <= active_nxt;
            // New line in, window step out
            case ({eol_acc, rotate})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: fill_q <= fill_q;
            endcase
            // Padding covers one row group after the last row
            if (eol_acc && last_row) begin
                padding_q <= 1'b1;
            end else if (sync.line_done) begin
                padding_q <= 1'b0;
            end
        end
    end

    a_active_onehot: assert property (@(posedge clk) disable iff (!aresetn)
        $onehot(active_q));

    a_no_blocked_write: assert property (@(posedge clk) disable iff (!aresetn)
        (|wr_sel) |-> sync.in_ready);

    // A window step never takes more lines than are buffered
    a_fill_no_underflow: assert property (@(posedge clk) disable iff (!aresetn)
        rotate |-> (fill_q != fill_t'(0) || eol_acc));

endmodule

//--- verilog/ring_sync_if.sv
// **************************************************
// Ring sync between write and read sides
// **************************************************
`timescale 1ns/1ps

interface ring_sync_if
    import line_buffer_pkg::*;
();

    // Lines buffered, relative to the newest tap of the read window
    fill_t     fill;

    // High for one row group after the last input row
    logic      padding;

    // Input acceptance
    logic      in_ready;

    // Oldest tap memory, next-state value for the store pipeline
    line_sel_t active_sel;

    // Last beat of the last repeat of a row group accepted
    logic      line_done;

    modport write (
        output fill,
        output padding,
        output in_ready,
        output active_sel,
        input  line_done
    );

    modport read (
        input  fill,
        input  padding,
        input  in_ready,
        input  active_sel,
        output line_done
    );

endinterface

//--- verilog/line_buffer_pkg.sv
// **************************************************
// Bicubic line buffer types
// **************************************************
`include "line_buffer_consts.svh"

package line_buffer_pkg;

    // One pixel
    typedef logic [`LB_PIXEL_WIDTH-1:0] pixel_t;

    // Column index within a line
    typedef logic [$clog2(`LB_IMAGE_WIDTH)-1:0] col_t;

    // Row group index, frame has height plus one groups
    typedef logic [$clog2(`LB_IMAGE_HEIGHT+1)-1:0] row_t;

    // Repeat index
    typedef logic [1:0] rep_t;

    // Buffered line count
    typedef logic [2:0] fill_t;

    // One-hot memory selection
    typedef logic [`LB_NUM_LINES-1:0] line_sel_t;

    // Four vertical taps, index 0 is the oldest row
    typedef pixel_t [3:0] tap_vec_t;

    // Edge padding codes
    typedef enum logic [2:0] {
        PAD_NONE,
        PAD_TOP0,
        PAD_TOP1,
        PAD_BOT1,
        PAD_BOT0
    } pad_e;

    // Read side FSM
    typedef enum logic {
        RD_IDLE,
        RD_STREAM
    } rd_state_e;

endpackage

//--- verilog/line_buffer_consts.svh
// **************************************************
// Bicubic line buffer constants
// **************************************************
`ifndef LINE_BUFFER_CONSTS_SVH
`define LINE_BUFFER_CONSTS_SVH

// Image geometry, kept small for short simulations
`define LB_IMAGE_WIDTH 16
`define LB_IMAGE_HEIGHT 6

// Bits per pixel
`define LB_PIXEL_WIDTH 8

// Ring of line memories
`define LB_NUM_LINES 5

// Vertical upscale, each row group is sent this many times
`define LB_REPEAT 4

// Read latency of one line memory in cycles
`define LB_RAM_LATENCY 1

`endif
